//--- vlog.f
+incdir+source
source/rv32_types_pkg.sv
source/dbus_pkg.sv
source/store_align.sv
source/load_extender.sv
source/mem_wb_register.sv
source/mem_stage_ctrl.sv
source/mem_stage_top.sv
verification/tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_stage \
  -o sim_tb_mem_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb_mem_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

//--- verification/tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage;

  logic                       CLK;
  logic                       nRST;
  logic                       halt;
  logic                       in_valid;
  rv32_types_pkg::mem_op_t    op;
  rv32_types_pkg::load_type_t load_type;
  rv32_types_pkg::word_t      addr;
  rv32_types_pkg::word_t      store_data;
  rv32_types_pkg::word_t      alu_result;
  rv32_types_pkg::reg_idx_t   rd;
  logic                       reg_wen;
  logic                       advance;
  logic                       dbus_ren;
  logic                       dbus_wen;
  rv32_types_pkg::word_t      dbus_addr;
  dbus_pkg::byte_en_t         dbus_byte_en;
  rv32_types_pkg::word_t      dbus_wdata;
  logic                       dbus_busy;
  rv32_types_pkg::word_t      dbus_rdata;
  logic                       flush;
  logic                       flush_done;
  logic                       wb_valid;
  rv32_types_pkg::reg_idx_t   wb_rd;
  logic                       wb_wen;
  rv32_types_pkg::word_t      wb_data;
  logic                       wb_mal_l;
  logic                       wb_mal_s;

  integer seed = 32'h09482a3f;
  int errors = 0;
  int tests = 0;
  rv32_types_pkg::word_t bus_mem [64];   // what the memory responder holds
  rv32_types_pkg::word_t model_mem [64]; // reference copy, written from the rules

  mem_stage_top mem_stage_top_i (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic check_word(input string name, input rv32_types_pkg::word_t exp,
                            input rv32_types_pkg::word_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %0s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_lanes(input string name, input dbus_pkg::byte_en_t exp,
                             input dbus_pkg::byte_en_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %0s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %0s expected %b actual %b", name, exp, act);
    end
  endtask

  function automatic dbus_pkg::byte_en_t lanes_of(input rv32_types_pkg::load_type_t lt,
                                                  input rv32_types_pkg::word_t a);
    case (lt)
      rv32_types_pkg::LB, rv32_types_pkg::LBU: return 4'b0001 << a[1:0];
      rv32_types_pkg::LH, rv32_types_pkg::LHU: return 4'b0011 << (a[1] * 2);
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic mal_of(input rv32_types_pkg::load_type_t lt,
                                  input rv32_types_pkg::word_t a);
    if (lt == rv32_types_pkg::LH || lt == rv32_types_pkg::LHU)
      return a[0];
    if (lt == rv32_types_pkg::LW)
      return a[1:0] != 2'b00;
    return 1'b0;
  endfunction

  function automatic rv32_types_pkg::word_t wdata_of(input rv32_types_pkg::load_type_t lt,
                                                     input rv32_types_pkg::word_t sd);
    if (lt == rv32_types_pkg::LB)
      return {sd[7:0], sd[7:0], sd[7:0], sd[7:0]};
    if (lt == rv32_types_pkg::LH)
      return {sd[15:0], sd[15:0]};
    return sd;
  endfunction

  // expected load result taken from the model memory
  function automatic rv32_types_pkg::word_t load_of(input rv32_types_pkg::load_type_t lt,
                                                    input rv32_types_pkg::word_t a);
    rv32_types_pkg::word_t w;
    logic [7:0]  b;
    logic [15:0] h;
    w = model_mem[a[7:2]];
    b = 8'(w >> (8 * a[1:0]));
    h = 16'(w >> (16 * a[1]));
    case (lt)
      rv32_types_pkg::LB:  return $unsigned(32'($signed(b)));
      rv32_types_pkg::LBU: return 32'(b);
      rv32_types_pkg::LH:  return $unsigned(32'($signed(h)));
      rv32_types_pkg::LHU: return 32'(h);
      default:             return w;
    endcase
  endfunction

  task automatic run_instr(input string name, input rv32_types_pkg::mem_op_t o,
                           input rv32_types_pkg::load_type_t lt,
                           input rv32_types_pkg::word_t a, input rv32_types_pkg::word_t sd);
    int cycles;
    int busy_left;
    int flush_wait;
    int flush_cnt;
    int errs_before;
    logic access;
    logic seen_adv;
    logic req_seen;
    logic mal;
    logic rw;
    rv32_types_pkg::reg_idx_t r;
    rv32_types_pkg::word_t alu;
    rv32_types_pkg::word_t exp_data;
    dbus_pkg::byte_en_t lanes;
    rv32_types_pkg::word_t held_wdata;
    rv32_types_pkg::word_t held_addr;
    errs_before = errors;
    mal = (o == rv32_types_pkg::OP_LOAD || o == rv32_types_pkg::OP_STORE) && mal_of(lt, a);
    access = (o == rv32_types_pkg::OP_LOAD || o == rv32_types_pkg::OP_STORE) && !mal;
    lanes = lanes_of(lt, a);
    r = 5'($random(seed));
    rw = 1'($random(seed));
    alu = $random(seed);
    exp_data = (access && o == rv32_types_pkg::OP_LOAD) ? load_of(lt, a) : alu;
    busy_left = access ? ($unsigned($random(seed)) % 4) : 0;
    flush_wait = 0;
    flush_cnt = 0;
    req_seen = 1'b0;
    seen_adv = 1'b0;
    cycles = 0;
    @(posedge CLK);
    in_valid <= 1'b1;
    op <= o;
    load_type <= lt;
    addr <= a;
    store_data <= sd;
    alu_result <= alu;
    rd <= r;
    reg_wen <= rw;
    dbus_busy <= (busy_left > 0);
    dbus_rdata <= bus_mem[a[7:2]];
    while (!seen_adv) begin
      @(negedge CLK);
      check_flag({name, " ren"}, access && o == rv32_types_pkg::OP_LOAD, dbus_ren);
      check_flag({name, " wen"}, access && o == rv32_types_pkg::OP_STORE, dbus_wen);
      if (access && !req_seen) begin
        req_seen = 1'b1;
        held_wdata = dbus_wdata;
        held_addr = dbus_addr;
      end else if (access) begin
        check_word({name, " held wdata"}, held_wdata, dbus_wdata);
        check_word({name, " held addr"}, held_addr, dbus_addr);
      end
      if (advance && dbus_busy && access)
        check_flag({name, " advance while busy"}, 1'b0, advance);
      if (flush) begin
        flush_cnt++;
        flush_wait = 1 + ($unsigned($random(seed)) % 4);
      end
      if (access && !dbus_busy) begin
        check_lanes({name, " lanes"}, lanes, dbus_byte_en);
        check_word({name, " addr"}, {a[31:2], 2'b00}, dbus_addr);
        if (o == rv32_types_pkg::OP_STORE) begin
          check_word({name, " wdata"}, wdata_of(lt, sd), dbus_wdata);
          for (int i = 0; i < 4; i++) begin
            if (dbus_byte_en[i])
              bus_mem[dbus_addr[7:2]][8*i +: 8] = dbus_wdata[8*i +: 8];
            if (lanes[i]) // model byte straight from the store data
              model_mem[a[7:2]][8*i +: 8] = (lt == rv32_types_pkg::LB) ? sd[7:0] :
                (lt == rv32_types_pkg::LH) ? sd[8*(i%2) +: 8] : sd[8*i +: 8];
          end
        end
      end
      if (o == rv32_types_pkg::OP_FENCE && advance)
        check_flag({name, " advance without flush_done"}, 1'b1, flush_done);
      if (advance) begin
        seen_adv = 1'b1;
      end else begin
        cycles++;
        if (cycles >= 50) begin
          $display("timeout: no advance for %0s after 50 cycles", name);
          $display("Checks failed");
          $finish;
        end
        @(posedge CLK);
        if (busy_left > 0)
          busy_left--;
        dbus_busy <= (busy_left > 0);
        if (flush_wait > 0) begin
          flush_wait--;
          flush_done <= (flush_wait == 0);
        end else begin
          flush_done <= 1'b0;
        end
      end
    end
    @(posedge CLK);
    in_valid <= 1'b0;
    dbus_busy <= 1'b0;
    flush_done <= 1'b0;
    cycles = 0;
    @(negedge CLK);
    while (!wb_valid) begin
      cycles++;
      if (cycles >= 50) begin
        $display("timeout: no writeback for %0s after 50 cycles", name);
        $display("Checks failed");
        $finish;
      end
      @(negedge CLK);
    end
    check_word({name, " wb_rd"}, 32'(r), 32'(wb_rd));
    check_word({name, " wb_data"}, exp_data, wb_data);
    check_flag({name, " wb_wen"}, rw & ~(mal && o == rv32_types_pkg::OP_LOAD), wb_wen);
    check_flag({name, " wb_mal_l"}, mal && o == rv32_types_pkg::OP_LOAD, wb_mal_l);
    check_flag({name, " wb_mal_s"}, mal && o == rv32_types_pkg::OP_STORE, wb_mal_s);
    if (o == rv32_types_pkg::OP_FENCE)
      check_word({name, " flush pulses"}, 32'd1, 32'(flush_cnt));
    tests++;
    if (errors == errs_before)
      $display("test %0s %0d: ok", name, tests);
    else
      $display("test %0s %0d: %0d errors", name, tests, errors - errs_before);
  endtask

  function automatic rv32_types_pkg::load_type_t pick_type(input int n);
    int k;
    k = $unsigned($random(seed)) % n;
    case (k)
      0: return rv32_types_pkg::LB;
      1: return rv32_types_pkg::LH;
      2: return rv32_types_pkg::LW;
      3: return rv32_types_pkg::LBU;
      default: return rv32_types_pkg::LHU;
    endcase
  endfunction

  // aligned address inside the 64-word window
  function automatic rv32_types_pkg::word_t pick_addr(input rv32_types_pkg::load_type_t lt);
    rv32_types_pkg::word_t a;
    a = $random(seed) & 32'h0000_00ff;
    if (lt == rv32_types_pkg::LW)
      a[1:0] = 2'b00;
    else if (lt == rv32_types_pkg::LH || lt == rv32_types_pkg::LHU)
      a[0] = 1'b0;
    return a;
  endfunction

  initial begin
    rv32_types_pkg::load_type_t lt;
    rv32_types_pkg::word_t a;
    for (int i = 0; i < 64; i++) begin
      bus_mem[i] = (32'h9e37_79b9 * (i + 1)) ^ (i << 20) ^ i;
      model_mem[i] = bus_mem[i];
    end
    nRST = 1'b0;
    halt = 1'b0;
    in_valid = 1'b0;
    op = rv32_types_pkg::OP_NONE;
    load_type = rv32_types_pkg::LW;
    addr = '0;
    store_data = '0;
    alu_result = '0;
    rd = '0;
    reg_wen = 1'b0;
    dbus_busy = 1'b0;
    dbus_rdata = '0;
    flush_done = 1'b0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_flag("reset ren", 1'b0, dbus_ren);
    check_flag("reset wen", 1'b0, dbus_wen);
    check_flag("reset flush", 1'b0, flush);
    check_flag("reset advance", 1'b0, advance);
    check_flag("reset wb_valid", 1'b0, wb_valid);
    for (int i = 0; i < 20; i++) begin
      lt = pick_type(3); // stores use the signed codes
      run_instr("store", rv32_types_pkg::OP_STORE, lt, pick_addr(lt), $random(seed));
    end
    for (int i = 0; i < 30; i++) begin
      lt = pick_type(5);
      run_instr("load", rv32_types_pkg::OP_LOAD, lt, pick_addr(lt), '0);
    end
    for (int i = 0; i < 12; i++) begin
      lt = (i % 2) ? rv32_types_pkg::LW : rv32_types_pkg::LH;
      a = pick_addr(lt) | 32'h1;
      run_instr("misaligned", (i % 3) ? rv32_types_pkg::OP_LOAD : rv32_types_pkg::OP_STORE,
                lt, a, $random(seed));
    end
    for (int i = 0; i < 40; i++) begin
      lt = pick_type(5);
      case ($unsigned($random(seed)) % 3)
        0: run_instr("mixed store", rv32_types_pkg::OP_STORE, pick_type(3), pick_addr(lt),
                     $random(seed));
        1: run_instr("mixed load", rv32_types_pkg::OP_LOAD, lt, pick_addr(lt), '0);
        default: run_instr("alu", rv32_types_pkg::OP_NONE, lt, $random(seed), '0);
      endcase
    end
    for (int i = 0; i < 4; i++)
      run_instr("fence", rv32_types_pkg::OP_FENCE, rv32_types_pkg::LW, '0, '0);
    for (int i = 0; i < 2; i++) begin
      // faulting store, then faulting load, so each flag is set before the clear
      run_instr("halt setup", i ? rv32_types_pkg::OP_LOAD : rv32_types_pkg::OP_STORE,
                rv32_types_pkg::LW, 32'h2, $random(seed));
      @(posedge CLK);
      halt <= 1'b1;
      @(posedge CLK);
      @(negedge CLK);
      check_flag("halt wb_valid", 1'b0, wb_valid);
      check_word("halt wb_rd", 32'd0, 32'(wb_rd));
      check_flag("halt wb_wen", 1'b0, wb_wen);
      check_word("halt wb_data", 32'd0, wb_data);
      check_flag("halt wb_mal_l", 1'b0, wb_mal_l);
      check_flag("halt wb_mal_s", 1'b0, wb_mal_s);
      @(posedge CLK);
      halt <= 1'b0;
      tests++;
      $display("test halt %0d: done", tests);
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- source/mem_stage_top.sv
`timescale 1ns/10ps
`include "mem_stage_macros.svh"

module mem_stage_top (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       halt,
  input  logic                       in_valid,
  input  rv32_types_pkg::mem_op_t    op,
  input  rv32_types_pkg::load_type_t load_type,
  input  rv32_types_pkg::word_t      addr,
  input  rv32_types_pkg::word_t      store_data,
  input  rv32_types_pkg::word_t      alu_result,
  input  rv32_types_pkg::reg_idx_t   rd,
  input  logic                       reg_wen,
  output logic                       advance,
  output logic                       dbus_ren,
  output logic                       dbus_wen,
  output rv32_types_pkg::word_t      dbus_addr,
  output dbus_pkg::byte_en_t         dbus_byte_en,
  output rv32_types_pkg::word_t      dbus_wdata,
  input  logic                       dbus_busy,
  input  rv32_types_pkg::word_t      dbus_rdata,
  output logic                       flush,
  input  logic                       flush_done,
  output logic                       wb_valid,
  output rv32_types_pkg::reg_idx_t   wb_rd,
  output logic                       wb_wen,
  output rv32_types_pkg::word_t      wb_data,
  output logic                       wb_mal_l,
  output logic                       wb_mal_s
);

  logic misaligned;
  logic bus_done;

  assign dbus_addr = {addr[`WORD_W-1:2], 2'b00}; // word address, lanes select bytes

  mem_stage_ctrl mem_stage_ctrl_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .in_valid  (in_valid),
    .op        (op),
    .misaligned(misaligned),
    .dbus_busy (dbus_busy),
    .flush_done(flush_done),
    .dbus_ren  (dbus_ren),
    .dbus_wen  (dbus_wen),
    .flush     (flush),
    .advance   (advance),
    .bus_done  (bus_done)
  );

  store_align store_align_i (
    .load_type (load_type),
    .addr      (addr),
    .store_data(store_data),
    .byte_en   (dbus_byte_en),
    .misaligned(misaligned),
    .wdata     (dbus_wdata)
  );

  mem_wb_register mem_wb_register_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .bus_done  (bus_done),
    .advance   (advance),
    .rdata     (dbus_rdata),
    .in_valid  (in_valid),
    .op        (op),
    .load_type (load_type),
    .byte_en   (dbus_byte_en),
    .alu_result(alu_result),
    .rd        (rd),
    .reg_wen   (reg_wen),
    .misaligned(misaligned),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_wen    (wb_wen),
    .wb_data   (wb_data),
    .wb_mal_l  (wb_mal_l),
    .wb_mal_s  (wb_mal_s)
  );

endmodule

//--- source/mem_stage_ctrl.sv
`timescale 1ns/10ps

module mem_stage_ctrl (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    halt,
  input  logic                    in_valid,
  input  rv32_types_pkg::mem_op_t op,
  input  logic                    misaligned,
  input  logic                    dbus_busy,
  input  logic                    flush_done,
  output logic                    dbus_ren,
  output logic                    dbus_wen,
  output logic                    flush,
  output logic                    advance,
  output logic                    bus_done
);

  dbus_pkg::mem_state_t state;
  dbus_pkg::mem_state_t next_state;
  logic                 is_load;
  logic                 is_store;

  assign is_load  = (op == rv32_types_pkg::OP_LOAD);
  assign is_store = (op == rv32_types_pkg::OP_STORE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      state <= dbus_pkg::IDLE;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    dbus_ren   = 1'b0;
    dbus_wen   = 1'b0;
    flush      = 1'b0;
    advance    = 1'b0;
    bus_done   = 1'b0;
    case (state)
      dbus_pkg::IDLE: begin
        if (in_valid && !halt) begin
          case (op)
            rv32_types_pkg::OP_NONE: begin
              advance = 1'b1; // nothing to do here
            end
            rv32_types_pkg::OP_LOAD, rv32_types_pkg::OP_STORE: begin
              if (misaligned) begin
                advance = 1'b1; // reported as exception, no request
              end else begin
                dbus_ren = is_load;
                dbus_wen = is_store;
                if (!dbus_busy) begin
                  bus_done = 1'b1; // zero wait state
                  advance  = 1'b1;
                end else begin
                  next_state = dbus_pkg::BUS_WAIT;
                end
              end
            end
            rv32_types_pkg::OP_FENCE: begin
              next_state = dbus_pkg::FLUSH_START;
            end
          endcase
        end
      end
      dbus_pkg::BUS_WAIT: begin
        dbus_ren = is_load; // execute holds its inputs, so these stay put
        dbus_wen = is_store;
        if (!dbus_busy) begin
          bus_done   = 1'b1;
          advance    = 1'b1;
          next_state = dbus_pkg::IDLE;
        end
      end
      dbus_pkg::FLUSH_START: begin
        flush      = 1'b1;
        next_state = dbus_pkg::FLUSH_WAIT;
      end
      dbus_pkg::FLUSH_WAIT: begin
        if (flush_done) begin
          advance    = 1'b1;
          next_state = dbus_pkg::IDLE;
        end
      end
    endcase
  end

  // nothing retires while the bus is busy
  a_no_adv_busy: assert property (@(posedge CLK) disable iff (!nRST)
    dbus_busy |-> !advance);

  // the cache only answers the pending flush
  a_flush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    flush_done |-> state == dbus_pkg::FLUSH_WAIT);

endmodule

//--- source/mem_wb_register.sv
`timescale 1ns/10ps

module mem_wb_register (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       halt,
  input  logic                       bus_done,
  input  logic                       advance,
  input  rv32_types_pkg::word_t      rdata,
  input  logic                       in_valid,
  input  rv32_types_pkg::mem_op_t    op,
  input  rv32_types_pkg::load_type_t load_type,
  input  dbus_pkg::byte_en_t         byte_en,
  input  rv32_types_pkg::word_t      alu_result,
  input  rv32_types_pkg::reg_idx_t   rd,
  input  logic                       reg_wen,
  input  logic                       misaligned,
  output logic                       wb_valid,
  output rv32_types_pkg::reg_idx_t   wb_rd,
  output logic                       wb_wen,
  output rv32_types_pkg::word_t      wb_data,
  output logic                       wb_mal_l,
  output logic                       wb_mal_s
);

  rv32_types_pkg::word_t      rdata_q; // bus word from the completing load
  rv32_types_pkg::word_t      alu_q;
  rv32_types_pkg::word_t      ext_data;
  rv32_types_pkg::load_type_t ltype_q;
  dbus_pkg::byte_en_t         lanes_q;
  logic                       is_load_q;
  logic                       mal_l;
  logic                       mal_s;
  logic                       good_load;

  assign mal_l     = (op == rv32_types_pkg::OP_LOAD) & misaligned;
  assign mal_s     = (op == rv32_types_pkg::OP_STORE) & misaligned;
  assign good_load = (op == rv32_types_pkg::OP_LOAD) & ~misaligned;

  always_ff @(posedge CLK) begin
    if (bus_done && good_load)
      rdata_q <= rdata;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_valid  <= 1'b0;
      wb_wen    <= 1'b0;
      wb_mal_l  <= 1'b0;
      wb_mal_s  <= 1'b0;
      is_load_q <= 1'b0;
    end else if (halt) begin
      wb_valid  <= 1'b0;
      wb_wen    <= 1'b0;
      wb_mal_l  <= 1'b0;
      wb_mal_s  <= 1'b0;
      is_load_q <= 1'b0;
    end else begin
      wb_valid <= advance & in_valid; // one pulse per retired instruction
      if (advance) begin
        wb_wen    <= reg_wen & ~mal_l; // faulting load writes nothing
        wb_mal_l  <= mal_l;
        wb_mal_s  <= mal_s;
        is_load_q <= good_load;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (halt) begin
      wb_rd   <= '0;
      alu_q   <= '0;
      ltype_q <= '0;
      lanes_q <= '0;
    end else if (advance) begin
      wb_rd   <= rd;
      alu_q   <= alu_result; // also the faulting address on a misaligned load
      ltype_q <= load_type;
      lanes_q <= byte_en;
    end
  end

  load_extender load_extender_i (
    .load_type(ltype_q),
    .byte_en  (lanes_q),
    .rdata    (rdata_q),
    .ext_data (ext_data)
  );

  assign wb_data = is_load_q ? ext_data : alu_q;

  // completion from the ctrl block must belong to a bus access
  a_done_is_access: assert property (@(posedge CLK) disable iff (!nRST)
    bus_done |-> (op == rv32_types_pkg::OP_LOAD || op == rv32_types_pkg::OP_STORE));

endmodule

//--- source/load_extender.sv
`timescale 1ns/10ps

module load_extender (
  input  rv32_types_pkg::load_type_t load_type,
  input  dbus_pkg::byte_en_t         byte_en,
  input  rv32_types_pkg::word_t      rdata,
  output rv32_types_pkg::word_t      ext_data
);

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // right-justify the addressed lane
  always_comb begin
    case (byte_en)
      4'b0010: lane_byte = rdata[15:8];
      4'b0100: lane_byte = rdata[23:16];
      4'b1000: lane_byte = rdata[31:24];
      default: lane_byte = rdata[7:0];
    endcase
  end

  assign lane_half = (byte_en == dbus_pkg::BE_HI_HALF) ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (load_type)
      rv32_types_pkg::LB:  ext_data = {{24{lane_byte[7]}}, lane_byte};
      rv32_types_pkg::LBU: ext_data = {24'b0, lane_byte};
      rv32_types_pkg::LH:  ext_data = {{16{lane_half[15]}}, lane_half};
      rv32_types_pkg::LHU: ext_data = {16'b0, lane_half};
      default:             ext_data = rdata; // full word
    endcase
  end

endmodule

//--- source/store_align.sv
`timescale 1ns/10ps

module store_align (
  input  rv32_types_pkg::load_type_t load_type,
  input  rv32_types_pkg::word_t      addr,
  input  rv32_types_pkg::word_t      store_data,
  output dbus_pkg::byte_en_t         byte_en,
  output logic                       misaligned,
  output rv32_types_pkg::word_t      wdata
);

  // lanes and alignment from the access size
  always_comb begin
    byte_en    = dbus_pkg::BE_NONE;
    misaligned = 1'b0;
    case (load_type)
      rv32_types_pkg::LB, rv32_types_pkg::LBU: begin
        byte_en = dbus_pkg::byte_en_t'(dbus_pkg::BE_BYTE0 << addr[1:0]); // any byte is fine
      end
      rv32_types_pkg::LH, rv32_types_pkg::LHU: begin
        byte_en    = addr[1] ? dbus_pkg::BE_HI_HALF : dbus_pkg::BE_LO_HALF;
        misaligned = addr[0]; // odd half address
      end
      rv32_types_pkg::LW: begin
        byte_en    = dbus_pkg::BE_WORD;
        misaligned = (addr[1:0] != 2'b00);
      end
      default: begin
        byte_en    = dbus_pkg::BE_NONE; // unused funct3 codes
        misaligned = 1'b0;
      end
    endcase
  end

  // the memory picks its lanes out of the replicated word
  always_comb begin
    case (load_type)
      rv32_types_pkg::LB, rv32_types_pkg::LBU: wdata = {4{store_data[7:0]}};
      rv32_types_pkg::LH, rv32_types_pkg::LHU: wdata = {2{store_data[15:0]}};
      default:                                 wdata = store_data;
    endcase
  end

endmodule

//--- source/dbus_pkg.sv
`include "mem_stage_macros.svh"

package dbus_pkg;

  typedef logic [`BYTE_EN_W-1:0] byte_en_t; // little-endian lane enables

  // lane patterns before shifting by the address
  localparam byte_en_t BE_NONE    = 4'b0000;
  localparam byte_en_t BE_BYTE0   = 4'b0001;
  localparam byte_en_t BE_LO_HALF = 4'b0011;
  localparam byte_en_t BE_HI_HALF = 4'b1100;
  localparam byte_en_t BE_WORD    = 4'b1111;

  // control sequencing of the memory stage
  typedef enum logic [1:0] {
    IDLE,        // waiting for an instruction from execute
    BUS_WAIT,    // request held until busy drops
    FLUSH_START, // single flush strobe
    FLUSH_WAIT   // waiting for the cache to finish
  } mem_state_t;

endpackage

//--- source/rv32_types_pkg.sv
`include "mem_stage_macros.svh"

package rv32_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;      // data and address word
  typedef logic [4:0]         reg_idx_t;   // destination register number
  typedef logic [2:0]         load_type_t; // funct3 field of a load or store
  typedef logic [1:0]         mem_op_t;    // operation class from execute

  // funct3 codes, stores reuse the signed ones
  localparam load_type_t LB  = 3'b000;
  localparam load_type_t LH  = 3'b001;
  localparam load_type_t LW  = 3'b010;
  localparam load_type_t LBU = 3'b100;
  localparam load_type_t LHU = 3'b101;

  // operation classes
  localparam mem_op_t OP_NONE  = 2'b00; // alu result passes through
  localparam mem_op_t OP_LOAD  = 2'b01;
  localparam mem_op_t OP_STORE = 2'b10;
  localparam mem_op_t OP_FENCE = 2'b11; // cache flush, no bus access

endpackage

//--- source/mem_stage_macros.svh
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// data path and address width of the core
`define WORD_W 32

// one enable per byte lane of the data bus
`define BYTE_EN_W 4

`endif
